/* vec_input.txt */
# columns: tag x y z expected_length expected_sat, values in hex q16.16
# tag v is one vector, tag g is one idle cycle
v 00000000 00000000 00000000 00000000 0
v 00010000 00000000 00000000 00010000 0
v 00030000 00040000 00000000 00050000 0
v 00010000 00020000 00020000 00030000 0
v 00000000 00000000 FFFD0000 00030000 0
v 012C0000 00480000 0022A45C 00800012 1
v 00400000 00000000 00000000 00400000 0
v FFFF0000 FFFE0000 00020000 00030000 0
g
v 00028000 00000000 00000000 00028000 0
v 00000000 00018000 00000000 00018000 0
v FF060000 FFB80000 FFDD5BA4 00800012 1
v 00000000 FFC00000 00000000 00400000 0
g
g
v 00008000 00000000 00000000 00008000 0
v 00480000 7FFFFFFF 0022A45C 00800012 1
v 00030000 00040000 00000000 00050000 0
v 00000000 00000000 00000000 00000000 0
v 00010000 00020000 00020000 00030000 0
v 00000000 00000000 00010000 00010000 0
v 00020000 00010000 00020000 00030000 0

/* files.f */
+incdir+.
fixed_pkg.sv
vec_pkg.sv
lane_if.sv
vec_dispatch.sv
inv_sqrt.sv
vec_length_lane.sv
len_collect.sv
vec_length_array.sv
tb_checker.sv
tb_vec_length.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing
LINTFLAGS = --lint-only --timing
TOP       = tb_vec_length
RTL_TOP   = vec_length_array
FILELIST  = files.f
OBJ_DIR   = obj_dir
PASS_MSG  = *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* tb_vec_length.sv */
`timescale 1ns/100ps
`include "vec_consts.svh"

module tb_vec_length;

    localparam string DATA_FILE = "vec_input.txt";
    // idle cycles allowed past the stimulus before giving up
    localparam int    SLACK_CYCLES = 20;

    logic                          clk;
    logic                          rst;
    logic                          in_valid;
    logic signed [`WORD_WIDTH-1:0] in_x;
    logic signed [`WORD_WIDTH-1:0] in_y;
    logic signed [`WORD_WIDTH-1:0] in_z;
    logic                          out_valid;
    logic signed [`WORD_WIDTH-1:0] out_length;
    logic [`SEQ_WIDTH-1:0]         out_seq;
    logic                          out_sat;

    // stimulus table, one entry per data line
    bit                            is_vec [$];
    logic signed [`WORD_WIDTH-1:0] tab_x [$];
    logic signed [`WORD_WIDTH-1:0] tab_y [$];
    logic signed [`WORD_WIDTH-1:0] tab_z [$];
    int                            gap_before [$];
    int                            num_vec;
    int                            total_gaps;
    bit                            table_ok;
    bit                            table_ready;
    int                            seed;

    int outputs_seen;
    int err_len;
    int err_lat;
    int err_seq;
    int err_sat;
    int err_other;

    // ------------------------------------------------
    // clock, 8 ns period
    // ------------------------------------------------
    initial clk = 1'b0;
    always #4 clk = ~clk;

    vec_length_array dut0 (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_x       (in_x),
        .in_y       (in_y),
        .in_z       (in_z),
        .out_valid  (out_valid),
        .out_length (out_length),
        .out_seq    (out_seq),
        .out_sat    (out_sat)
    );

    tb_checker chk0 (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .out_valid    (out_valid),
        .out_length   (out_length),
        .out_seq      (out_seq),
        .out_sat      (out_sat),
        .outputs_seen (outputs_seen),
        .err_len      (err_len),
        .err_lat      (err_lat),
        .err_seq      (err_seq),
        .err_sat      (err_sat),
        .err_other    (err_other)
    );

    // read the data file, draw the random gaps up front
    task automatic load_table(output bit ok);
        int          fd;
        int          n;
        string       line;
        string       tag;
        logic [31:0] vx;
        logic [31:0] vy;
        logic [31:0] vz;
        int          gap;
        ok = 1'b0;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("could not open stimulus file %s", DATA_FILE);
        end else begin
            ok = 1'b1;
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n == 0) begin
                    break;
                end
                // skip blank and comment lines
                if (line.len() < 2 || line.getc(0) == 8'h23) begin
                    continue;
                end
                n = $sscanf(line, "%s %h %h %h", tag, vx, vy, vz);
                if (tag == "g") begin
                    is_vec.push_back(1'b0);
                    tab_x.push_back('0);
                    tab_y.push_back('0);
                    tab_z.push_back('0);
                    gap_before.push_back(0);
                    total_gaps++;
                end else if (tag == "v" && n == 4) begin
                    // every fourth vector gets 0 to 3 extra idle cycles
                    gap = 0;
                    if (num_vec % 4 == 3) begin
                        gap = int'($unsigned($random(seed)) % 4);
                    end
                    is_vec.push_back(1'b1);
                    tab_x.push_back(vx);
                    tab_y.push_back(vy);
                    tab_z.push_back(vz);
                    gap_before.push_back(gap);
                    total_gaps += gap;
                    num_vec++;
                end
            end
            $fclose(fd);
        end
    endtask

    // hold in_valid low for n cycles
    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    // ------------------------------------------------
    // stimulus and final report
    // ------------------------------------------------
    initial begin
        in_valid    = 1'b0;
        in_x        = '0;
        in_y        = '0;
        in_z        = '0;
        rst         = 1'b0;
        seed        = 15429;
        num_vec     = 0;
        total_gaps  = 0;
        table_ready = 1'b0;
        load_table(table_ok);
        if (!table_ok) begin
            $display("*** TEST FAILED ***");
            $finish;
        end else begin
            table_ready = 1'b1;
            // reset held for two edges
            repeat (2) @(posedge clk);
            rst <= 1'b1;
            for (int i = 0; i < is_vec.size(); i++) begin
                if (is_vec[i]) begin
                    idle_cycles(gap_before[i]);
                    @(posedge clk);
                    in_valid <= 1'b1;
                    in_x     <= tab_x[i];
                    in_y     <= tab_y[i];
                    in_z     <= tab_z[i];
                end else begin
                    idle_cycles(1);
                end
            end
            idle_cycles(1);
            // drain, then a few more cycles to catch stray outputs
            wait (outputs_seen >= num_vec);
            repeat (4) @(posedge clk);
            $display(
                "errors: length %0d, latency %0d, order %0d, clamp %0d, other %0d, outputs %0d/%0d",
                err_len, err_lat, err_seq, err_sat, err_other, outputs_seen, num_vec);
            if (err_len + err_lat + err_seq + err_sat + err_other == 0
                    && outputs_seen == num_vec) begin
                $display("*** TEST PASSED ***");
            end else begin
                $display("*** TEST FAILED ***");
            end
            $finish;
        end
    end

    // watchdog sized from the stimulus length
    initial begin
        wait (table_ready);
        repeat (num_vec + total_gaps + SLACK_CYCLES) @(posedge clk);
        $display("timeout: the DUT did not deliver all %0d results in time", num_vec);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* tb_checker.sv */
`timescale 1ns/100ps
`include "vec_consts.svh"

module tb_checker (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_valid,
    input  logic                          out_valid,
    input  logic signed [`WORD_WIDTH-1:0] out_length,
    input  logic [`SEQ_WIDTH-1:0]         out_seq,
    input  logic                          out_sat,
    output int                            outputs_seen,
    output int                            err_len,
    output int                            err_lat,
    output int                            err_seq,
    output int                            err_sat,
    output int                            err_other
);

    localparam int LEN_TOL_LSB = 64;
    // dispatcher 1 + lane 6 + collector 1
    localparam int LATENCY     = 8;

    logic signed [`WORD_WIDTH-1:0] exp_len [$];
    logic                          exp_sat [$];
    // cycle stamp of each accepted input
    int                            in_cycle [$];
    int                            cycle;
    int                            next_idx;
    logic [`SEQ_WIDTH-1:0]         exp_seq;

    // expected length and clamp flag from every vector line
    task automatic load_expected();
        int          fd;
        int          n;
        string       line;
        string       tag;
        logic [31:0] vx;
        logic [31:0] vy;
        logic [31:0] vz;
        logic [31:0] vlen;
        logic [31:0] vsat;
        fd = $fopen("vec_input.txt", "r");
        if (fd == 0) begin
            $display("checker could not open vec_input.txt");
            err_other++;
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n == 0) begin
                break;
            end
            if (line.len() < 2 || line.getc(0) == 8'h23) begin
                continue;
            end
            n = $sscanf(line, "%s %h %h %h %h %h", tag, vx, vy, vz, vlen, vsat);
            if (tag == "v" && n == 6) begin
                exp_len.push_back(vlen);
                exp_sat.push_back(vsat[0]);
            end
        end
        $fclose(fd);
    endtask

    initial begin
        outputs_seen = 0;
        err_len      = 0;
        err_lat      = 0;
        err_seq      = 0;
        err_sat      = 0;
        err_other    = 0;
        cycle        = 0;
        next_idx     = 0;
        exp_seq      = '0;
        load_expected();
    end

    // ------------------------------------------------
    // sample ports on the rising edge
    // ------------------------------------------------
    always @(posedge clk) begin : watch
        longint diff;
        int     lat;
        cycle = cycle + 1;
        if (!rst) begin
            if (out_valid) begin
                err_other++;
                $display("error %0t: out_valid high during reset", $time);
            end
        end else begin
            if (in_valid) begin
                in_cycle.push_back(cycle);
            end
            if (out_valid) begin
                outputs_seen++;
                if (in_cycle.size() == 0 || next_idx >= exp_len.size()) begin
                    err_other++;
                    $display("error %0t: out_valid with no matching input", $time);
                end else begin
                    lat = cycle - in_cycle.pop_front();
                    if (lat != LATENCY) begin
                        err_lat++;
                        $display("error %0t: vector %0d latency %0d cycles, expected %0d",
                                 $time, next_idx, lat, LATENCY);
                    end
                    if (out_seq != exp_seq) begin
                        err_seq++;
                        $display("error %0t: out_seq %0d, expected %0d",
                                 $time, out_seq, exp_seq);
                    end
                    diff = longint'(out_length) - longint'(exp_len[next_idx]);
                    if (diff < 0) begin
                        diff = -diff;
                    end
                    if (diff > LEN_TOL_LSB) begin
                        err_len++;
                        $display("error %0t: vector %0d length %h, expected %h",
                                 $time, next_idx, out_length, exp_len[next_idx]);
                    end
                    if (out_sat !== exp_sat[next_idx]) begin
                        err_sat++;
                        $display("error %0t: vector %0d out_sat %b, expected %b",
                                 $time, next_idx, out_sat, exp_sat[next_idx]);
                    end
                    next_idx++;
                    exp_seq = exp_seq + 1'b1;
                end
            end
        end
    end

endmodule

/* vec_length_array.sv */
`timescale 1ns/100ps
`include "vec_consts.svh"

module vec_length_array
    import fixed_pkg::*;
    import vec_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  fp_t                   in_x,
    input  fp_t                   in_y,
    input  fp_t                   in_z,
    output logic                  out_valid,
    output fp_t                   out_length,
    output logic [`SEQ_WIDTH-1:0] out_seq,
    output logic                  out_sat
);

    vec3 in_vec;

    // dispatcher to lanes
    lane_if #(.payload_t(vec3))  vec_bus [`NUM_LANES] ();
    // lanes to collector
    lane_if #(.payload_t(len_t)) len_bus [`NUM_LANES] ();

    assign in_vec = '{x: in_x, y: in_y, z: in_z};

    // ------------------------------------------------
    // clamp, tag and deal, 1 cycle
    // ------------------------------------------------
    vec_dispatch u_dispatch (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_vec   (in_vec),
        .lanes    (vec_bus)
    );

    // ------------------------------------------------
    // length lanes, 6 cycles each
    // ------------------------------------------------
    for (genvar g = 0; g < `NUM_LANES; g++) begin : g_lane
        vec_length_lane u_lane (
            .clk  (clk),
            .rst  (rst),
            .vin  (vec_bus[g]),
            .rout (len_bus[g])
        );
    end

    // merge back to one stream, 1 cycle
    len_collect u_collect (
        .clk        (clk),
        .rst        (rst),
        .results    (len_bus),
        .out_valid  (out_valid),
        .out_length (out_length),
        .out_seq    (out_seq),
        .out_sat    (out_sat)
    );

endmodule

/* len_collect.sv */
`timescale 1ns/100ps
`include "vec_consts.svh"

module len_collect
    import fixed_pkg::*;
    import vec_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    lane_if.sink                  results [`NUM_LANES],
    output logic                  out_valid,
    output fp_t                   out_length,
    output logic [`SEQ_WIDTH-1:0] out_seq,
    output logic                  out_sat
);

    logic [`NUM_LANES-1:0] hit;
    len_t                  lane_res [`NUM_LANES];
    logic [`SEQ_WIDTH-1:0] lane_seq [`NUM_LANES];
    logic [`NUM_LANES-1:0] lane_sat;

    fp_t                   merged_len;
    logic [`SEQ_WIDTH-1:0] merged_seq;
    logic                  merged_sat;

    // flatten the interface array
    for (genvar g = 0; g < `NUM_LANES; g++) begin : g_tap
        assign hit[g]      = results[g].valid;
        assign lane_res[g] = results[g].data;
        assign lane_seq[g] = results[g].seq;
        assign lane_sat[g] = results[g].sat;
    end

    // ------------------------------------------------
    // one-hot or-merge
    // ------------------------------------------------
    // the staggered deal leaves at most one lane valid
    always_comb begin
        merged_len = '0;
        merged_seq = '0;
        merged_sat = 1'b0;
        for (int i = 0; i < `NUM_LANES; i++) begin
            merged_len |= lane_res[i].length & {`WORD_WIDTH{hit[i]}};
            merged_seq |= lane_seq[i] & {`SEQ_WIDTH{hit[i]}};
            merged_sat |= lane_sat[i] & hit[i];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= |hit;
        end
    end

    // output payload
    always_ff @(posedge clk) begin
        out_length <= merged_len;
        out_seq    <= merged_seq;
        out_sat    <= merged_sat;
    end

endmodule

/* vec_length_lane.sv */
`timescale 1ns/100ps
`include "vec_consts.svh"

module vec_length_lane
    import fixed_pkg::*;
    import vec_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    lane_if.sink   vin,
    lane_if.source rout
);

    // matches the inv_sqrt start to done latency
    localparam int ALIGN_DEPTH = 4;

    fp_t                   sum_r;
    logic                  start_r;
    logic [`SEQ_WIDTH-1:0] seq_r;
    logic                  sat_r;

    // side data riding next to inv_sqrt
    fp_t                   sum_d [ALIGN_DEPTH];
    logic [`SEQ_WIDTH-1:0] seq_d [ALIGN_DEPTH];
    logic                  sat_d [ALIGN_DEPTH];

    fp_t                   inv_root;
    logic                  root_done;

    // ------------------------------------------------
    // control strobes
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            start_r    <= 1'b0;
            rout.valid <= 1'b0;
        end else begin
            start_r    <= vin.valid;
            rout.valid <= root_done;
        end
    end

    // ------------------------------------------------
    // sum of squares, delay line, final product
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        // stage 1, squared length and tags
        sum_r <= vec3_dot(vin.data, vin.data);
        seq_r <= vin.seq;
        sat_r <= vin.sat;
        // delay line head
        sum_d[0] <= sum_r;
        seq_d[0] <= seq_r;
        sat_d[0] <= sat_r;
        for (int i = 1; i < ALIGN_DEPTH; i++) begin
            sum_d[i] <= sum_d[i-1];
            seq_d[i] <= seq_d[i-1];
            sat_d[i] <= sat_d[i-1];
        end
        // length = sum * 1/sqrt(sum)
        rout.data.length <= fp_mul(sum_d[ALIGN_DEPTH-1], inv_root);
        rout.seq         <= seq_d[ALIGN_DEPTH-1];
        rout.sat         <= sat_d[ALIGN_DEPTH-1];
    end

    inv_sqrt u_inv_sqrt (
        .clk   (clk),
        .rst   (rst),
        .start (start_r),
        .x     (sum_r),
        .y     (inv_root),
        .done  (root_done)
    );

endmodule

/* inv_sqrt.sv */
`timescale 1ns/100ps
`include "vec_consts.svh"

module inv_sqrt
    import fixed_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  fp_t  x,
    output fp_t  y,
    output logic done
);

    // 1.5 in q format
    localparam fp_t THREE_HALVES = fp_t'(3 <<< (`FRAC_BITS - 1));
    localparam int  NR_STEPS     = 3;

    logic       busy;
    logic [1:0] step_cnt;
    fp_t        x_r;
    fp_t        y_r;
    fp_t        seed;

    // index of the highest set bit
    function automatic int lead_one(input fp_t v);
        int pos;
        pos = 0;
        for (int i = 0; i < `WORD_WIDTH; i++) begin
            if (v[i]) begin
                pos = i;
            end
        end
        return pos;
    endfunction

    // one newton step, y * (1.5 - x*y*y/2)
    function automatic fp_t nr_step(input fp_t xv, input fp_t yv);
        fp_t xy;
        fp_t xyy;
        fp_t h;
        // x*y first, keeps small inputs from saturating
        xy  = fp_mul(xv, yv);
        xyy = fp_mul(xy, yv);
        h   = THREE_HALVES - (xyy >>> 1);
        return fp_mul(yv, h);
    endfunction

    // ------------------------------------------------
    // seed from the leading one
    // ------------------------------------------------
    // x ~ 2^(msb-F), so 1/sqrt(x) raw ~ 2^((3F-msb)/2)
    always_comb begin
        int  msb;
        int  expo;
        fp_t pow2;
        msb  = lead_one(x);
        expo = 3 * `FRAC_BITS - msb;
        pow2 = fp_t'(1) <<< (expo >> 1);
        if (x <= 0) begin
            // zero in, zero out
            seed = '0;
        end else if (expo[0]) begin
            // half exponent dropped, 1.25 * 2^k
            seed = pow2 + (pow2 >>> 2);
        end else begin
            // even exponent, 0.75 * 2^k
            seed = pow2 - (pow2 >>> 2);
        end
    end

    // ------------------------------------------------
    // step counter, start then three refinements
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            busy     <= 1'b0;
            step_cnt <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (busy) begin
                step_cnt <= step_cnt + 2'd1;
                if (step_cnt == 2'(NR_STEPS - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end else if (start) begin
                busy     <= 1'b1;
                step_cnt <= '0;
            end
        end
    end

    // operand and running estimate
    always_ff @(posedge clk) begin
        if (!busy && start) begin
            x_r <= x;
            y_r <= seed;
        end else if (busy) begin
            y_r <= nr_step(x_r, y_r);
        end
    end

    assign y = y_r;

endmodule

/* vec_dispatch.sv */
`timescale 1ns/100ps
`include "vec_consts.svh"

module vec_dispatch
    import fixed_pkg::*;
    import vec_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   in_valid,
    input  vec3    in_vec,
    lane_if.source lanes [`NUM_LANES]
);

    localparam int  PTR_W    = $clog2(`NUM_LANES);
    localparam fp_t CLAMP_HI = fp_t'(`MAX_COMPONENT);
    localparam fp_t CLAMP_LO = -CLAMP_HI;

    logic [PTR_W-1:0]      rr_ptr;
    logic [`SEQ_WIDTH-1:0] seq_cnt;
    vec3                   clamped;
    logic                  any_sat;

    // limit one component to the clamp range
    function automatic fp_t clamp_comp(input fp_t v);
        if (v > CLAMP_HI) begin
            return CLAMP_HI;
        end
        if (v < CLAMP_LO) begin
            return CLAMP_LO;
        end
        return v;
    endfunction

    // ------------------------------------------------
    // clamp and flag
    // ------------------------------------------------
    always_comb begin
        clamped.x = clamp_comp(in_vec.x);
        clamped.y = clamp_comp(in_vec.y);
        clamped.z = clamp_comp(in_vec.z);
        // any component changed means the vector was clamped
        any_sat   = (clamped.x != in_vec.x) || (clamped.y != in_vec.y)
                 || (clamped.z != in_vec.z);
    end

    // ------------------------------------------------
    // round-robin pointer and tag counter
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            rr_ptr  <= '0;
            seq_cnt <= '0;
        end else if (in_valid) begin
            seq_cnt <= seq_cnt + 1'b1;
            rr_ptr  <= (rr_ptr == PTR_W'(`NUM_LANES - 1)) ? '0 : rr_ptr + 1'b1;
        end
    end

    // one register slice per lane, only the picked lane loads
    for (genvar g = 0; g < `NUM_LANES; g++) begin : g_deal
        logic pick;
        assign pick = in_valid && (rr_ptr == PTR_W'(g));

        always_ff @(posedge clk) begin
            if (!rst) begin
                lanes[g].valid <= 1'b0;
            end else begin
                lanes[g].valid <= pick;
            end
        end

        // payload held until the lane's next turn
        always_ff @(posedge clk) begin
            if (pick) begin
                lanes[g].data <= clamped;
                lanes[g].seq  <= seq_cnt;
                lanes[g].sat  <= any_sat;
            end
        end
    end

endmodule

/* lane_if.sv */
`timescale 1ns/100ps
`include "vec_consts.svh"

// one tagged item, present only while valid is high
interface lane_if #(
    parameter type payload_t = logic
);

    // item strobe, no handshake
    logic                  valid;
    // payload, vector or length
    payload_t              data;
    // input order tag
    logic [`SEQ_WIDTH-1:0] seq;
    // set when the vector was clamped
    logic                  sat;

    // producer side
    modport source (output valid, output data, output seq, output sat);

    // consumer side
    modport sink (input valid, input data, input seq, input sat);

endinterface

/* vec_pkg.sv */
package vec_pkg;

    import fixed_pkg::*;

    // ------------------------------------------------
    // vector types
    // ------------------------------------------------
    // three-component vector, x in the top word
    typedef struct packed {
        fp_t x;
        fp_t y;
        fp_t z;
    } vec3;

    // result payload of one lane
    typedef struct packed {
        fp_t length;
    } len_t;

    // ------------------------------------------------
    // vector math
    // ------------------------------------------------
    // dot product, each term rescaled by fp_mul
    // no overflow once the components are clamped
    function automatic fp_t vec3_dot(input vec3 a, input vec3 b);
        fp_t px;
        fp_t py;
        fp_t pz;
        px = fp_mul(a.x, b.x);
        py = fp_mul(a.y, b.y);
        pz = fp_mul(a.z, b.z);
        return px + py + pz;
    endfunction

endpackage

/* fixed_pkg.sv */
`include "vec_consts.svh"

package fixed_pkg;

    // signed q-format scalar
    typedef logic signed [`WORD_WIDTH-1:0] fp_t;

    // saturation bounds of one word
    localparam fp_t FP_MAX = {1'b0, {(`WORD_WIDTH-1){1'b1}}};
    localparam fp_t FP_MIN = {1'b1, {(`WORD_WIDTH-1){1'b0}}};

    // half an lsb after rescale, for round to nearest
    localparam logic signed [2*`WORD_WIDTH-1:0] ROUND_BIAS =
        (2*`WORD_WIDTH)'(1) <<< (`FRAC_BITS - 1);

    // ------------------------------------------------
    // q-format multiply with rounding and saturation
    // ------------------------------------------------
    function automatic fp_t fp_mul(input fp_t a, input fp_t b);
        logic signed [2*`WORD_WIDTH-1:0] prod;
        logic signed [2*`WORD_WIDTH-1:0] scaled;
        // full double-width product
        prod   = a * b;
        // drop the extra fraction bits
        scaled = (prod + ROUND_BIAS) >>> `FRAC_BITS;
        if (scaled > FP_MAX) begin
            return FP_MAX;
        end
        if (scaled < FP_MIN) begin
            return FP_MIN;
        end
        return scaled[`WORD_WIDTH-1:0];
    endfunction

endpackage

/* vec_consts.svh */
`ifndef VEC_CONSTS_SVH
`define VEC_CONSTS_SVH

// ------------------------------------------------
// fixed-point word layout
// ------------------------------------------------
// signed q16.16, one full word
`define WORD_WIDTH 32
`define FRAC_BITS 16

// ------------------------------------------------
// engine shape
// ------------------------------------------------
// inv_sqrt holds its value 4 cycles, so 4 lanes minimum
`define NUM_LANES 4
// clamp magnitude per component, 100.0 in q16.16
// keeps the sum of squares below 32768
`define MAX_COMPONENT (100 <<< `FRAC_BITS)
// sequence tag, wraps at 256
`define SEQ_WIDTH 8

`endif
